// File: dv/erx_checker.sv
// erx checker
// register, timer and remap model fed from the erx_core ports, compares every response
`timescale 1ns/100ps
`default_nettype none
`include "erx_settings.svh"

module erx_checker (
   input  wire                  clk,
   input  wire                  nreset,
   input  wire                  mi_en,
   input  wire                  mi_we,
   input  erx_pkg::mi_addr_t    mi_addr,
   input  erx_pkg::word_t       mi_din,
   input  erx_pkg::word_t       mi_dout,
   input  wire                  rx_access,
   input  erx_pkg::rx_addr_t    rx_addr,
   input  erx_pkg::word_t       rx_data,
   input  wire                  rx_out_access,
   input  erx_pkg::rx_addr_t    rx_out_addr,
   input  erx_pkg::word_t       rx_out_data,
   input  wire [8:0]            gpio_datain,
   input  wire [14:0]           rx_flags,
   input  erx_pkg::tap_value_t  idelay_value,
   input  wire                  load_taps,
   input  wire                  mmu_enable,
   input  wire                  test_mode,
   input  wire [127:0]          test_name,   // ascii, for error lines
   input  erx_pkg::word_t       exp_val,     // table value for the current read
   input  erx_pkg::word_t       exp_mask,
   output int                   err_count
);

   import erx_pkg::*;

   word_t       cfg, offset, tdata;            // register model
   logic [63:0] img;                           // idelay image, both words
   logic [8:0]  gpio_q;
   logic [2:0]  sticky;
   logic [7:0]  cnt, lim;                      // idle timer model
   logic        tmo;
   logic        rd_pend, tx_pend, acc_pend, taps_pend;
   word_t       rd_exp, rd_val, rd_mask, tx_data, acc_data;
   rx_addr_t    tx_addr;
   logic [5:0]  idx;
   logic        wr;

   // lane n = {image bit 36+n, image bits 4n+3..4n}, lane 8 on top
   function automatic tap_value_t tap_lanes(input logic [63:0] image);
      tap_value_t v;
      for (int n = 0; n < 9; n++)
         v[5*n +: 5] = {image[36+n], image[4*n +: 4]};
      return v;
   endfunction

   // static: selected top bits take the pattern; dynamic: add base; 0 and 3 pass
   function automatic rx_addr_t remapped(input rx_addr_t a);
      rx_addr_t r;
      r = a;
      if (cfg[3:2] == 2'd1) begin
         for (int b = 0; b < 12; b++)
            if (cfg[4+b])
               r[20+b] = cfg[16+b];
      end else if (cfg[3:2] == 2'd2) begin
         r = a + offset;
      end
      return r;
   endfunction

   task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act) begin
         err_count++;
         $display("MISMATCH %0s %0s expected %h actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic report(input string msg);
      err_count++;
      $display("error in %0s: %0s", test_name, msg);
   endtask

   initial err_count = 0;

   // ####################################################################
   // compare at each edge, then advance the model
   // ####################################################################
   always @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cfg       = '0;
         offset    = '0;
         tdata     = '0;
         img       = '0;
         gpio_q    = '0;
         sticky    = '0;
         cnt       = '0;
         tmo       = 1'b0;
         rd_pend   = 1'b0;
         tx_pend   = 1'b0;
         acc_pend  = 1'b0;
         taps_pend = 1'b0;
      end else begin
         idx = mi_addr[`ERX_RFAW+1:2];
         wr  = mi_en && mi_we;
         // responses owed from the last edge
         if (rd_pend) begin
            compare("read data", rd_exp, mi_dout);
            compare("read vs table", rd_val & rd_mask, mi_dout & rd_mask);
         end else begin
            compare("idle read bus", 0, mi_dout);        // zero between reads
         end
         if (rx_out_access !== tx_pend)
            report(tx_pend ? "no rx_out_access one cycle after rx_access"
                           : "rx_out_access without a matching rx_access");
         else if (tx_pend) begin
            compare("rx_out_addr", tx_addr, rx_out_addr);
            compare("rx_out_data", tx_data, rx_out_data);
         end
         if (load_taps !== taps_pend)
            report("load_taps does not pulse once after the IDELAY1 write");
         compare("idelay_value", tap_lanes(img), idelay_value);
         compare("test_mode", cfg[0], test_mode);
         compare("mmu_enable", cfg[1], mmu_enable);

         // what the next edge should show, from pre-edge state
         rd_pend = mi_en && !mi_we;
         rd_val  = exp_val;
         rd_mask = exp_mask;
         case (idx)
            `ERX_CFG:      rd_exp = cfg;
            `ERX_OFFSET:   rd_exp = offset;
            `ERX_GPIO:     rd_exp = {23'd0, gpio_q};
            `ERX_STATUS:   rd_exp = {16'd0, rx_flags[14:2], sticky};
            `ERX_TESTDATA: rd_exp = tdata;
            default:       rd_exp = '0;
         endcase
         tx_pend = rx_access && !cfg[0];
         if (rx_access) begin
            tx_addr = remapped(rx_addr);
            tx_data = rx_data;
         end
         taps_pend = wr && (idx == `ERX_IDELAY1);

         // accumulator, a host write wins
         if (wr && idx == `ERX_TESTDATA)
            tdata = mi_din;
         else if (acc_pend)
            tdata = tdata + acc_data;
         acc_pend = rx_access && cfg[0];
         acc_data = rx_data;

         // idle timer and sticky status
         case (cfg[29:28])
            2'd1:    lim = `ERX_TIMER_LIM1;
            2'd2:    lim = `ERX_TIMER_LIM2;
            2'd3:    lim = `ERX_TIMER_LIM3;
            default: lim = 8'd0;
         endcase
         sticky = sticky | {rx_flags[1:0], tmo};
         // pulse when an idle cycle steps the count onto the limit
         tmo    = (lim != 8'd0) && !rx_access && (cnt == lim - 8'd1);
         if (rx_access || lim == 8'd0)
            cnt = 8'd0;
         else if (cnt < lim)
            cnt = cnt + 8'd1;
         gpio_q = gpio_datain;

         if (wr && idx == `ERX_CFG)
            cfg = mi_din;
         if (wr && idx == `ERX_OFFSET)
            offset = mi_din;
         if (wr && idx == `ERX_IDELAY0)
            img[31:0] = mi_din;
         if (wr && idx == `ERX_IDELAY1)
            img[63:32] = mi_din;
      end
   end

endmodule

`default_nettype wire

// File: dv/erx_tb.sv
// erx testbench
// table of register and transaction steps applied to erx_core, erx_checker compares
`timescale 1ns/100ps
`default_nettype none

module erx_tb;

   import erx_pkg::*;

   typedef enum logic [2:0] {WR, RD, RX, IDLE, PIN} op_t;

   typedef struct packed {
      logic [127:0] name;   // ascii test name
      op_t          op;
      logic [31:0]  addr;   // register byte address, strobe count for RX
      logic [31:0]  data;   // write data, idle cycles, {flags, gpio} for PIN
      logic [31:0]  exp;    // expected read value under mask
      logic [31:0]  mask;   // zero leaves the read to the model alone
   } entry_t;

   localparam int NUM = 34;

   logic         clk;
   logic         nreset;
   logic         mi_en;
   logic         mi_we;
   mi_addr_t     mi_addr;
   word_t        mi_din;
   word_t        mi_dout;
   logic         rx_access;
   rx_addr_t     rx_addr;
   word_t        rx_data;
   logic         rx_out_access;
   rx_addr_t     rx_out_addr;
   word_t        rx_out_data;
   logic [8:0]   gpio_datain;
   logic [14:0]  rx_flags;
   tap_value_t   idelay_value;
   logic         load_taps;
   logic         mmu_enable;
   logic         test_mode;
   logic [127:0] test_name;
   word_t        exp_val;
   word_t        exp_mask;
   int           err_count;

   entry_t       tbl [NUM];
   int           n_rows;
   int           passes;
   int           fails;
   int           errs_before;
   int unsigned  seed;

   erx_core UUT (.*);
   erx_checker u_checker (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // 20 ns period
   end

   // run limit from table length and the longest step
   initial begin
      #(NUM * 300 * 20 + 2000);
      $display("watchdog expired before the test table finished");
      $display("TESTS FAILED");
      $finish;
   end

   task automatic add_row(input logic [127:0] name, input op_t op, input word_t addr,
                          input word_t data, input word_t exp, input word_t mask);
      tbl[n_rows] = {name, op, addr, data, exp, mask};
      n_rows++;
   endtask

   // ####################################################################
   // stimulus table
   // ####################################################################
   task automatic fill_table();
      add_row("rst_cfg",         RD,   'h00, 0,            0,            '1);
      add_row("rst_offset",      RD,   'h04, 0,            0,            '1);
      add_row("rst_gpio",        RD,   'h10, 0,            0,            '1);
      add_row("rst_status",      RD,   'h14, 0,            0,            '1);
      add_row("rst_testdata",    RD,   'h18, 0,            0,            '1);
      add_row("wr_offset",       WR,   'h04, 'h1234_5678,  0,            0);
      add_row("rd_offset",       RD,   'h04, 0,            'h1234_5678,  '1);
      add_row("rd_unmapped",     RD,   'h1c, 0,            0,            '1);
      add_row("wr_idelay0",      WR,   'h08, 'ha5c3_9e71,  0,            0);
      add_row("wr_idelay1",      WR,   'h0c, 'h0000_1f3b,  0,            0);
      add_row("set_pins",        PIN,  0,    'h2abc_01a5,  0,            0);
      add_row("rd_gpio",         RD,   'h10, 0,            'h0000_01a5,  '1);
      add_row("rx_passthru",     RX,   4,    0,            0,            0);
      add_row("wr_static",       WR,   'h00, 'h0a5a_f0f6,  0,            0);
      add_row("rd_cfg",          RD,   'h00, 0,            'h0a5a_f0f6,  '1);
      add_row("rx_static",       RX,   4,    0,            0,            0);
      add_row("wr_dynamic",      WR,   'h00, 'h0000_0008,  0,            0);
      add_row("rx_dynamic",      RX,   4,    0,            0,            0);
      add_row("wr_rsvd",         WR,   'h00, 'h0000_000c,  0,            0);
      add_row("rx_rsvd",         RX,   3,    0,            0,            0);
      add_row("wr_testdata",     WR,   'h18, 'h1000_0000,  0,            0);
      add_row("wr_testmode",     WR,   'h00, 'h0000_0001,  0,            0);
      add_row("rx_testmode",     RX,   5,    0,            0,            0);
      add_row("rd_testdata",     RD,   'h18, 0,            0,            0);
      add_row("timer_off",       WR,   'h00, 0,            0,            0);
      add_row("idle_300",        IDLE, 0,    300,          0,            0);
      add_row("rd_status_off",   RD,   'h14, 0,            0,            'h1);
      add_row("timer_lim1",      WR,   'h00, 'h1000_0000,  0,            0);
      add_row("idle_20",         IDLE, 0,    20,           0,            0);
      add_row("rd_status_to",    RD,   'h14, 0,            'h1,          'h1);
      add_row("set_flags",       PIN,  0,    'h0003_0000,  0,            0);
      add_row("rx_traffic",      RX,   2,    0,            0,            0);
      add_row("clear_flags",     PIN,  0,    0,            0,            0);
      add_row("rd_status_stick", RD,   'h14, 0,            'h7,          'h7);
   endtask

   // one table step, inputs change on the falling edge only
   task automatic apply_entry(input entry_t e);
      case (e.op)
         WR, RD: begin
            @(negedge clk);
            mi_en    = 1'b1;
            mi_we    = (e.op == WR);
            mi_addr  = e.addr[14:0];
            mi_din   = e.data;
            exp_val  = e.exp;
            exp_mask = (e.op == RD) ? e.mask : '0;
            @(negedge clk);
            mi_en    = 1'b0;
            mi_we    = 1'b0;
            exp_mask = '0;
         end
         RX: begin
            for (int k = 0; k < e.addr; k++) begin   // back to back strobes
               @(negedge clk);
               rx_access = 1'b1;
               rx_addr   = $urandom();
               rx_data   = $urandom();
            end
            @(negedge clk);
            rx_access = 1'b0;
         end
         IDLE: repeat (e.data) @(negedge clk);
         PIN: begin
            @(negedge clk);
            gpio_datain = e.data[8:0];
            rx_flags    = e.data[30:16];
         end
         default: @(negedge clk);
      endcase
   endtask

   initial begin
      nreset      = 1'b0;
      mi_en       = 1'b0;
      mi_we       = 1'b0;
      mi_addr     = '0;
      mi_din      = '0;
      rx_access   = 1'b0;
      rx_addr     = '0;
      rx_data     = '0;
      gpio_datain = '0;
      rx_flags    = '0;
      test_name   = "reset";
      exp_val     = '0;
      exp_mask    = '0;
      n_rows      = 0;
      passes      = 0;
      fails       = 0;
      seed        = 76515;
      void'($urandom(seed));   // seeded once for the whole run
      fill_table();
      repeat (4) @(negedge clk);
      nreset = 1'b1;

      for (int i = 0; i < n_rows; i++) begin
         errs_before = err_count;
         test_name   = tbl[i].name;
         apply_entry(tbl[i]);
         if (tbl[i].op != PIN)
            repeat (2) @(negedge clk);   // last response gets checked
         if (err_count == errs_before) begin
            passes++;
            $display("test %0s: ok", test_name);
         end else begin
            fails++;
            $display("test %0s: %0d errors", test_name, err_count - errs_before);
         end
      end

      $display("summary: %0d ok, %0d failing, %0d errors", passes, fails, err_count);
      if (err_count == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: rtl/erx_cfg.sv
// erx receive configuration register file
// mode/remap/timer config, tap values, gpio sample, status, test accumulator
`timescale 1ns/100ps
`default_nettype none
`include "erx_settings.svh"

module erx_cfg (
   input  wire                    clk,
   input  wire                    nreset,
   // register port
   input  wire                    mi_en,
   input  wire                    mi_we,
   input  erx_pkg::mi_addr_t      mi_addr,
   input  erx_pkg::word_t         mi_din,
   output erx_pkg::word_t         mi_dout,
   // test accumulator feed from remapper
   input  wire                    test_access,
   input  erx_pkg::word_t         test_data,
   // pins and status
   input  wire [8:0]              gpio_datain,
   input  wire [15:0]             rx_status,
   // config outputs
   output logic                   mmu_enable,
   output logic                   test_mode,
   output erx_pkg::remap_mode_t   remap_mode,
   output erx_pkg::remap_field_t  remap_sel,
   output erx_pkg::remap_field_t  remap_pattern,
   output erx_pkg::rx_addr_t      remap_base,
   output erx_pkg::timer_cfg_t    timer_cfg,
   output erx_pkg::tap_value_t    idelay_value,
   output logic                   load_taps
);

   import erx_pkg::*;

   logic [`ERX_RFAW-1:0] word_idx;   // register word index
   logic                 reg_write;
   logic                 reg_read;

   word_t       cfg_reg;
   word_t       offset_reg;
   word_t       testdata_reg;
   logic [8:0]  gpio_reg;
   logic [2:0]  status_sticky;
   logic [31:0] idelay_lo;           // tap image bits 31..0
   logic [12:0] idelay_hi;           // tap image bits 44..32, rest unused

   assign word_idx  = mi_addr[`ERX_RFAW+1:2];
   assign reg_write = mi_en & mi_we;
   assign reg_read  = mi_en & ~mi_we;

   // ####################################################################
   // config and remap base
   // ####################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cfg_reg    <= '0;
         offset_reg <= '0;
      end else if (reg_write) begin
         if (word_idx == `ERX_CFG)
            cfg_reg <= mi_din;
         if (word_idx == `ERX_OFFSET)
            offset_reg <= mi_din;
      end
   end

   // cfg field split
   assign test_mode     = cfg_reg[0];
   assign mmu_enable    = cfg_reg[1];     // stored only
   assign remap_mode    = remap_mode_t'(cfg_reg[3:2]);
   assign remap_sel     = cfg_reg[15:4];
   assign remap_pattern = cfg_reg[27:16];
   assign timer_cfg     = cfg_reg[29:28];
   assign remap_base    = offset_reg;

   // ####################################################################
   // input delay taps
   // ####################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         idelay_lo <= '0;
         idelay_hi <= '0;
         load_taps <= 1'b0;
      end else begin
         if (reg_write && word_idx == `ERX_IDELAY0)
            idelay_lo <= mi_din;
         if (reg_write && word_idx == `ERX_IDELAY1)
            idelay_hi <= mi_din[12:0];
         load_taps <= reg_write && (word_idx == `ERX_IDELAY1);  // 1 cycle late
      end
   end

   // lane n = {img[36+n], img[4n+3:4n]}, lane 8 is frame
   for (genvar n = 0; n < 8; n++) begin : g_lane
      assign idelay_value[5*n+4:5*n] = {idelay_hi[4+n], idelay_lo[4*n+3:4*n]};
   end
   assign idelay_value[44:40] = {idelay_hi[12], idelay_hi[3:0]};  // frame

   // ####################################################################
   // gpio sample, status, test accumulator
   // ####################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         gpio_reg      <= '0;
         status_sticky <= '0;
      end else begin
         gpio_reg      <= gpio_datain;                    // free running
         status_sticky <= status_sticky | rx_status[2:0]; // bit 0 = timeout
      end
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         testdata_reg <= '0;
      else if (reg_write && word_idx == `ERX_TESTDATA)
         testdata_reg <= mi_din;                          // host write wins
      else if (test_access)
         testdata_reg <= testdata_reg + test_data;        // wraps mod 2^32
   end

   // ####################################################################
   // readback, one cycle after the read strobe, zero otherwise
   // ####################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         mi_dout <= '0;
      end else if (reg_read) begin
         case (word_idx)
            `ERX_CFG:      mi_dout <= cfg_reg;
            `ERX_OFFSET:   mi_dout <= offset_reg;
            `ERX_GPIO:     mi_dout <= {23'd0, gpio_reg};
            `ERX_STATUS:   mi_dout <= {16'd0, rx_status[15:3], status_sticky};
            `ERX_TESTDATA: mi_dout <= testdata_reg;
            default:       mi_dout <= '0;   // idelay regs are write only
         endcase
      end else begin
         mi_dout <= '0;
      end
   end

endmodule

`default_nettype wire

// File: rtl/erx_core.sv
// erx receive config subsystem top
// register file beside the address remapper and the idle timer
`timescale 1ns/100ps
`default_nettype none

module erx_core (
   input  wire                  clk,
   input  wire                  nreset,
   // register port
   input  wire                  mi_en,
   input  wire                  mi_we,
   input  erx_pkg::mi_addr_t    mi_addr,
   input  erx_pkg::word_t       mi_din,
   output erx_pkg::word_t       mi_dout,
   // transaction in
   input  wire                  rx_access,
   input  erx_pkg::rx_addr_t    rx_addr,
   input  erx_pkg::word_t       rx_data,
   // transaction out
   output logic                 rx_out_access,
   output erx_pkg::rx_addr_t    rx_out_addr,
   output erx_pkg::word_t       rx_out_data,
   // pins and flags
   input  wire [8:0]            gpio_datain,
   input  wire [14:0]           rx_flags,
   // config out
   output erx_pkg::tap_value_t  idelay_value,
   output logic                 load_taps,
   output logic                 mmu_enable,
   output logic                 test_mode
);

   import erx_pkg::*;

   remap_mode_t  remap_mode;
   remap_field_t remap_sel;
   remap_field_t remap_pattern;
   rx_addr_t     remap_base;
   timer_cfg_t   timer_cfg;
   logic         test_access;
   word_t        test_data;
   logic         timeout;
   logic [15:0]  rx_status;

   assign rx_status = {rx_flags, timeout};   // timeout lands in sticky bit 0

   erx_cfg u_cfg (
      .clk, .nreset,
      .mi_en, .mi_we, .mi_addr, .mi_din, .mi_dout,
      .test_access, .test_data,
      .gpio_datain, .rx_status,
      .mmu_enable, .test_mode,
      .remap_mode, .remap_sel, .remap_pattern, .remap_base,
      .timer_cfg, .idelay_value, .load_taps
   );

   erx_remap u_remap (
      .clk, .nreset,
      .rx_access, .rx_addr, .rx_data,
      .remap_mode, .remap_sel, .remap_pattern, .remap_base, .test_mode,
      .rx_out_access, .rx_out_addr, .rx_out_data,
      .test_access, .test_data
   );

   erx_timer u_timer (
      .clk, .nreset,
      .rx_access, .timer_cfg,
      .timeout
   );

endmodule

`default_nettype wire

// File: rtl/erx_pkg.sv
// erx package
// shared vector types and the remap mode encoding
`default_nettype none

package erx_pkg;

   typedef logic [31:0] word_t;        // register / data word
   typedef logic [14:0] mi_addr_t;     // register port byte address
   typedef logic [31:0] rx_addr_t;     // transaction address
   typedef logic [11:0] remap_field_t; // covers addr[31:20]
   typedef logic [44:0] tap_value_t;   // 9 lanes x 5 bits, frame on top
   typedef logic [1:0]  timer_cfg_t;   // 0 = timer off

   // address remap modes, rsvd acts like none
   typedef enum logic [1:0] {
      REMAP_NONE    = 2'd0,
      REMAP_STATIC  = 2'd1,
      REMAP_DYNAMIC = 2'd2,
      REMAP_RSVD    = 2'd3
   } remap_mode_t;

endpackage

`default_nettype wire

// File: rtl/erx_remap.sv
// erx address remapper
// one registered stage, static/dynamic remap, test mode steers to accumulator
`timescale 1ns/100ps
`default_nettype none

module erx_remap (
   input  wire                    clk,
   input  wire                    nreset,
   // incoming transaction
   input  wire                    rx_access,
   input  erx_pkg::rx_addr_t      rx_addr,
   input  erx_pkg::word_t         rx_data,
   // config
   input  erx_pkg::remap_mode_t   remap_mode,
   input  erx_pkg::remap_field_t  remap_sel,
   input  erx_pkg::remap_field_t  remap_pattern,
   input  erx_pkg::rx_addr_t      remap_base,
   input  wire                    test_mode,
   // outgoing transaction
   output logic                   rx_out_access,
   output erx_pkg::rx_addr_t      rx_out_addr,
   output erx_pkg::word_t         rx_out_data,
   // test mode path
   output logic                   test_access,
   output erx_pkg::word_t         test_data
);

   import erx_pkg::*;

   rx_addr_t mapped_addr;
   word_t    data_q;        // shared by both outputs

   // address rewrite
   always_comb begin
      mapped_addr = rx_addr;
      case (remap_mode)
         REMAP_STATIC:  mapped_addr[31:20] = (rx_addr[31:20] & ~remap_sel) |
                                             (remap_pattern & remap_sel);
         REMAP_DYNAMIC: mapped_addr = rx_addr + remap_base;   // mod 2^32
         default:       mapped_addr = rx_addr;                // none, rsvd
      endcase
   end

   // strobes
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rx_out_access <= 1'b0;
         test_access   <= 1'b0;
      end else begin
         rx_out_access <= rx_access & ~test_mode;
         test_access   <= rx_access & test_mode;
      end
   end

   // payload, taken with every strobe
   always_ff @(posedge clk) begin
      if (rx_access) begin
         rx_out_addr <= mapped_addr;
         data_q      <= rx_data;
      end
   end

   assign rx_out_data = data_q;
   assign test_data   = data_q;

endmodule

`default_nettype wire

// File: rtl/erx_settings.svh
// erx settings
// register word offsets, register address width and idle timer limits
`ifndef ERX_SETTINGS_SVH
`define ERX_SETTINGS_SVH

// register word index comes from mi_addr[`ERX_RFAW+1:2]
`define ERX_RFAW 6

// register word offsets
`define ERX_CFG      6'd0   // mode bits, remap select/pattern, timer cfg
`define ERX_OFFSET   6'd1   // dynamic remap base
`define ERX_IDELAY0  6'd2   // tap image, low word
`define ERX_IDELAY1  6'd3   // tap image, high word, fires load_taps
`define ERX_GPIO     6'd4   // sampled pins
`define ERX_STATUS   6'd5   // sticky + live status
`define ERX_TESTDATA 6'd6   // test mode accumulator

// idle timer limits in cycles, picked by timer_cfg 1..3
`define ERX_TIMER_LIM1 8'd15
`define ERX_TIMER_LIM2 8'd63
`define ERX_TIMER_LIM3 8'd255

`endif

// File: rtl/erx_timer.sv
// erx idle timer
// counts idle cycles since the last rx_access, one-cycle timeout at the limit
`timescale 1ns/100ps
`default_nettype none
`include "erx_settings.svh"

module erx_timer (
   input  wire                  clk,
   input  wire                  nreset,
   input  wire                  rx_access,
   input  erx_pkg::timer_cfg_t  timer_cfg,
   output logic                 timeout
);

   import erx_pkg::*;

   logic [7:0] limit;
   logic [7:0] count;
   logic [7:0] count_nxt;

   // limit select, 0 keeps the counter parked at zero
   always_comb begin
      case (timer_cfg)
         2'd1:    limit = `ERX_TIMER_LIM1;
         2'd2:    limit = `ERX_TIMER_LIM2;
         2'd3:    limit = `ERX_TIMER_LIM3;
         default: limit = 8'd0;
      endcase
   end

   always_comb begin
      if (rx_access || limit == 8'd0)
         count_nxt = 8'd0;              // traffic or timer off clears the idle count
      else if (count < limit)
         count_nxt = count + 8'd1;
      else
         count_nxt = count;             // saturate at the limit
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         count   <= 8'd0;
         timeout <= 1'b0;
      end else begin
         count   <= count_nxt;
         // high in the cycle count first equals the limit
         timeout <= (limit != 8'd0) && (count_nxt == limit) && (count != limit);
      end
   end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+rtl
rtl/erx_pkg.sv
rtl/erx_cfg.sv
rtl/erx_remap.sv
rtl/erx_timer.sv
rtl/erx_core.sv
dv/erx_checker.sv
dv/erx_tb.sv
